// File: Makefile
# Verilator build and run of the Rice coder testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module rice_coder_tb -f rice_coder.f -Mdir obj_dir
	./obj_dir/Vrice_coder_tb | tee sim.log
	@if grep -qx "No errors" sim.log; then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: bench/rice_coder_checker.sv
// Bench checker. Models the bit stream from DUT inputs and drops its model on reset
`timescale 1ns/1ps
`include "rice_defs.svh"

module rice_coder_checker (
    input  logic              i_clk,
    input  logic              i_arst_n,
    input  logic              i_valid,
    input  rice_pkg::value_t  i_value,
    input  logic              i_flush,
    input  logic              i_word_valid,
    input  rice_pkg::word_t   i_word,
    input  logic              i_end,
    output int                o_mismatches,
    output int                o_unexpected,
    output int                o_missing,
    output int                o_pending,
    output int                o_expected_total,
    output int                o_words_seen
);

    bit               bit_q[$];
    rice_pkg::word_t  exp_q[$];

    int   mismatch_count = 0;
    int   unexpected_count = 0;
    int   missing_count = 0;
    int   pending = 0;
    int   expected_total = 0;
    int   words_seen = 0;
    logic end_seen = 1'b0;

    // Code for one sample, right-aligned, built bit by bit
    function automatic void rice_ref(input rice_pkg::value_t v, output rice_pkg::code_t code,
                                     output rice_pkg::len_t len);
        int q;
        q    = int'(v) / (1 << `RICE_K);
        code = '0;
        if (q >= `RICE_QMAX) begin
            for (int i = 0; i < `RICE_QMAX; i++) begin
                code = {code[30:0], 1'b1};
            end
            for (int i = `RICE_RAW_W - 1; i >= 0; i--) begin
                code = {code[30:0], v[i]};
            end
            len = rice_pkg::len_t'(`RICE_QMAX + `RICE_RAW_W);
        end else begin
            for (int i = 0; i < q; i++) begin
                code = {code[30:0], 1'b1};
            end
            code = {code[30:0], 1'b0};
            for (int i = `RICE_K - 1; i >= 0; i--) begin
                code = {code[30:0], v[i]};
            end
            len = rice_pkg::len_t'(q + 1 + `RICE_K);
        end
    endfunction

    // Every full group of 32 model bits becomes one expected word
    task automatic collect_words();
        rice_pkg::word_t w;
        w = '0;
        while (bit_q.size() >= 32) begin
            for (int i = 0; i < 32; i++) begin
                w = {w[30:0], bit_q.pop_front()};
            end
            exp_q.push_back(w);
            expected_total++;
        end
    endtask

    task automatic append_code(input rice_pkg::value_t v);
        rice_pkg::code_t code;
        rice_pkg::len_t  len;
        rice_ref(v, code, len);
        for (int i = int'(len) - 1; i >= 0; i--) begin
            bit_q.push_back(code[i]);
        end
        collect_words();
    endtask

    task automatic pad_to_word();
        if (bit_q.size() != 0) begin
            while (bit_q.size() < 32) begin
                bit_q.push_back(1'b0);
            end
            collect_words();
        end
    endtask

    task automatic compare_word(input rice_pkg::word_t w);
        rice_pkg::word_t exp;
        words_seen++;
        if (exp_q.size() == 0) begin
            unexpected_count++;
            $display("Output word %h at %0t arrived when no word was expected", w, $time);
        end else begin
            exp = exp_q.pop_front();
            if (w !== exp) begin
                mismatch_count++;
                $display("Mismatch at %0t: output word %h, expected %h", $time, w, exp);
            end
        end
    endtask

    always @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            // Reset throws away everything in flight inside the DUT
            bit_q.delete();
            exp_q.delete();
        end else begin
            // Output first, it belongs to inputs of earlier edges
            if (i_word_valid) begin
                compare_word(i_word);
            end
            if (i_valid) begin
                append_code(i_value);
            end else if (i_flush) begin
                pad_to_word();
            end
            if (i_end && !end_seen) begin
                end_seen = 1'b1;
                if (exp_q.size() != 0) begin
                    missing_count = exp_q.size();
                    $display("%0d expected words never came out of the DUT", missing_count);
                end
            end
        end
        pending = exp_q.size();
    end

    assign o_mismatches     = mismatch_count;
    assign o_unexpected     = unexpected_count;
    assign o_missing        = missing_count;
    assign o_pending        = pending;
    assign o_expected_total = expected_total;
    assign o_words_seen     = words_seen;

endmodule

// File: bench/rice_coder_props.sv
// Packer assertions, checked only while i_arst_n is high
`timescale 1ns/1ps

module rice_coder_props (
    input  logic             i_clk,
    input  logic             i_arst_n,
    input  logic             i_valid,
    input  logic             i_flush,
    input  rice_pkg::fill_t  i_fill,
    input  logic             i_word_valid
);

    // Number of failed assertions
    int fail_count = 0;

    // Flush travels apart from samples all the way down the pipeline
    a_no_valid_with_flush : assert property (
        @(posedge i_clk) disable iff (!i_arst_n) !(i_valid && i_flush)
    ) else begin
        $error("Packer saw code valid and flush in the same cycle");
        fail_count++;
    end

    // A full word is always shifted out, so the fill never reaches a word
    a_fill_below_word : assert property (
        @(posedge i_clk) disable iff (!i_arst_n) i_fill < 6'd32
    ) else begin
        $error("Packer fill reached 32 bits or more");
        fail_count++;
    end

    // After a flush the packer is empty and one code cannot fill a word
    a_flush_leaves_empty : assert property (
        @(posedge i_clk) disable iff (!i_arst_n) i_flush |=> ##1 !i_word_valid
    ) else begin
        $error("Packer emitted a word from the first code after a flush");
        fail_count++;
    end

endmodule

bind bit_packer rice_coder_props props_i (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_valid      (i_code.valid),
    .i_flush      (i_code.flush),
    .i_fill       (fill),
    .i_word_valid (o_word_valid)
);

// File: bench/rice_coder_tb.sv
// Testbench top. Short-code tests assume samples below 4*2**RICE_K give codes of at most 4+K bits
`timescale 1ns/1ps
`include "rice_defs.svh"

module rice_coder_tb;

    localparam int RESET_CYCLES = 8;
    localparam int DRAIN_MAX    = 10;
    localparam int LONG_COUNT   = 8;
    localparam int LONG_REPEAT  = 3;
    localparam int RAND_COUNT   = 400;
    localparam int MAX_GAP      = 3;

    // Upper bound on stimulus cycles with one term per test phase
    localparam int STIM_CYCLES = RESET_CYCLES
        + (32 + 1 + DRAIN_MAX)
        + (LONG_COUNT * LONG_REPEAT + 1 + DRAIN_MAX)
        + (3 + 1 + DRAIN_MAX + 1 + 5)
        + (RAND_COUNT * (MAX_GAP + 2) + 1 + DRAIN_MAX)
        + (10 + 4 + 4 + 6 + 8 + 1 + DRAIN_MAX + 2);
    localparam int CYCLE_LIMIT = STIM_CYCLES + 100;

    logic              clk;
    logic              arst_n;
    logic              valid;
    rice_pkg::value_t  value;
    logic              flush;
    logic              word_valid;
    rice_pkg::word_t   word;
    logic              run_done;

    int      mismatches;
    int      unexpected;
    int      missing;
    int      pending;
    int      expected_total;
    int      words_seen;
    int      tb_errors = 0;
    int      cycle_count;
    integer  seed;

    rice_pkg::value_t  long_vals [LONG_COUNT];

    rice_coder_top dut_i (
        .i_clk        (clk),
        .i_arst_n     (arst_n),
        .i_valid      (valid),
        .i_value      (value),
        .i_flush      (flush),
        .o_word_valid (word_valid),
        .o_word       (word)
    );

    rice_coder_checker chk_i (
        .i_clk            (clk),
        .i_arst_n         (arst_n),
        .i_valid          (valid),
        .i_value          (value),
        .i_flush          (flush),
        .i_word_valid     (word_valid),
        .i_word           (word),
        .i_end            (run_done),
        .o_mismatches     (mismatches),
        .o_unexpected     (unexpected),
        .o_missing        (missing),
        .o_pending        (pending),
        .o_expected_total (expected_total),
        .o_words_seen     (words_seen)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic drive(input logic v, input rice_pkg::value_t d, input logic f);
        @(posedge clk);
        #1;
        valid = v;
        value = d;
        flush = f;
    endtask

    task automatic send_sample(input rice_pkg::value_t d);
        drive(1'b1, d, 1'b0);
    endtask

    task automatic send_flush();
        drive(1'b0, '0, 1'b1);
    endtask

    task automatic idle(input int n);
        repeat (n) drive(1'b0, '0, 1'b0);
    endtask

    // Waits for every expected word and then gives a stray word time to show
    task automatic drain();
        idle(1);
        while (pending != 0) begin
            idle(1);
        end
        idle(4);
    endtask

    task automatic print_error_counts();
        $display("Error counts: mismatch %0d unexpected %0d missing %0d bench %0d assert %0d",
                 mismatches, unexpected, missing, tb_errors,
                 dut_i.pack_i.props_i.fail_count);
    endtask

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        tb_errors++;
        $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
        print_error_counts();
        $display("Errors found");
        $finish;
    end

    initial begin : stimulus
        int i;
        int rep;
        int gap;
        int sel;
        int raw;
        int seen_before;
        int exp_before;
        valid    = 1'b0;
        value    = '0;
        flush    = 1'b0;
        arst_n   = 1'b0;
        run_done = 1'b0;
        seed     = 32'h3354;
        long_vals = '{
            rice_pkg::value_t'(14 << `RICE_K),
            rice_pkg::value_t'((14 << `RICE_K) + (1 << `RICE_K) - 1),
            rice_pkg::value_t'(15 << `RICE_K),
            16'hFFFF,
            16'd1000,
            rice_pkg::value_t'((15 << `RICE_K) + (1 << `RICE_K) - 1),
            16'h8001,
            rice_pkg::value_t'((13 << `RICE_K) + 1)
        };
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // Short codes packed several to a word
        for (i = 0; i < 32; i++) begin
            send_sample(rice_pkg::value_t'(i % (4 << `RICE_K)));
        end
        send_flush();
        drain();

        // Longest normal codes and escapes with word boundaries inside codes
        for (rep = 0; rep < LONG_REPEAT; rep++) begin
            for (i = 0; i < LONG_COUNT; i++) begin
                send_sample(long_vals[i]);
            end
        end
        send_flush();
        drain();

        // A partial word gives one padded word and an empty flush gives none
        seen_before = words_seen;
        send_sample(16'd1);
        send_sample(16'd2);
        send_sample(16'd3);
        send_flush();
        drain();
        if (words_seen != seen_before + 1) begin
            tb_errors++;
            $display("Flush of a partial word gave %0d words instead of one",
                     words_seen - seen_before);
        end
        seen_before = words_seen;
        exp_before  = expected_total;
        send_flush();
        idle(5);
        if (words_seen != seen_before || expected_total != exp_before) begin
            tb_errors++;
            $display("Flush with an empty packer produced or predicted a word");
        end

        // Random samples with gaps and the odd flush
        for (i = 0; i < RAND_COUNT; i++) begin
            gap = $random(seed) & MAX_GAP;
            idle(gap);
            sel = $random(seed) & 3;
            raw = $random(seed);
            case (sel)
                0: send_sample(rice_pkg::value_t'(raw & 32'h000F));
                1: send_sample(rice_pkg::value_t'(raw & 32'h003F));
                2: send_sample(rice_pkg::value_t'(raw & 32'h00FF));
                default: send_sample(rice_pkg::value_t'(raw));
            endcase
            if (($random(seed) & 31) == 0) begin
                send_flush();
            end
        end
        send_flush();
        drain();

        // Reset with bits still held in the pipeline
        for (i = 0; i < 10; i++) begin
            send_sample(rice_pkg::value_t'(i * 7));
        end
        @(posedge clk);
        #1;
        valid  = 1'b0;
        flush  = 1'b0;
        arst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;
        // Twelve new bits are too few for a word
        for (i = 0; i < 4; i++) begin
            send_sample(16'd0);
        end
        idle(6);
        for (i = 0; i < 8; i++) begin
            send_sample(rice_pkg::value_t'(i * 5));
        end
        send_flush();
        drain();

        run_done = 1'b1;
        idle(2);
        print_error_counts();
        if (mismatches + unexpected + missing + tb_errors
                + dut_i.pack_i.props_i.fail_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: rice_coder.f
+incdir+rtl
rtl/rice_pkg.sv
rtl/rice_if.sv
rtl/rice_split.sv
rtl/rice_code_build.sv
rtl/bit_packer.sv
rtl/rice_coder_top.sv
bench/rice_coder_props.sv
bench/rice_coder_checker.sv
bench/rice_coder_tb.sv

// File: rtl/bit_packer.sv
// Stage 3. Packs codes MSB first into 32-bit words, no back-pressure so every word must be taken
`timescale 1ns/1ps

module bit_packer (
    input  logic             i_clk,
    input  logic             i_arst_n,
    code_if.dst              i_code,
    output logic             o_word_valid,
    output rice_pkg::word_t  o_word
);

    // Held bits sit at the top of acc, bits below the fill are stale
    logic [63:0]       acc;
    rice_pkg::fill_t   fill;

    logic [63:0]       keep_mask;
    logic [63:0]       held;
    rice_pkg::code_t   code_left;
    logic [63:0]       merged;
    logic [6:0]        sum;
    logic              emit_full;
    logic              emit_flush;

    always_comb begin
        keep_mask = ~({64{1'b1}} >> fill);
        held      = acc & keep_mask;

        // Move the new code to the top, then slide it under the held bits
        code_left = i_code.code << (6'd32 - i_code.len);
        merged    = held | ({code_left, 32'b0} >> fill);
        sum       = {1'b0, fill} + {1'b0, i_code.len};

        emit_full  = i_code.valid && (sum >= 7'd32);
        // A flush with nothing held produces no word
        emit_flush = i_code.flush && !i_code.valid && (fill != '0);
    end

    // Fill count and word strobe
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            fill         <= '0;
            o_word_valid <= 1'b0;
        end else begin
            o_word_valid <= emit_full || emit_flush;
            if (i_code.valid) begin
                if (emit_full) begin
                    fill <= rice_pkg::fill_t'(sum - 7'd32);
                end else begin
                    fill <= rice_pkg::fill_t'(sum);
                end
            end else if (i_code.flush) begin
                fill <= '0;
            end
        end
    end

    // Accumulator and output word
    always_ff @(posedge i_clk) begin
        if (i_code.valid) begin
            if (emit_full) begin
                o_word <= merged[63:32];
                acc    <= {merged[31:0], 32'b0};
            end else begin
                acc <= merged;
            end
        end else if (emit_flush) begin
            // Zero padding comes from the mask below the fill
            o_word <= held[63:32];
        end
    end

endmodule

// File: rtl/rice_code_build.sv
// Stage 2. Builds right-aligned Rice or escape codes, at most 31 bits, one per cycle
`timescale 1ns/1ps
`include "rice_defs.svh"

module rice_code_build (
    input  logic   i_clk,
    input  logic   i_arst_n,
    split_if.dst   i_split,
    code_if.src    o_code
);

    rice_pkg::code_t  unary_ones;
    rice_pkg::code_t  code_next;
    rice_pkg::len_t   len_next;

    always_comb begin
        // Run of quot ones in the low bits
        unary_ones = (rice_pkg::code_t'(1) << i_split.quot) - rice_pkg::code_t'(1);

        if (i_split.esc) begin
            // Escape prefix of RICE_QMAX ones, then the sample itself
            code_next = rice_pkg::code_t'({{`RICE_QMAX{1'b1}}, i_split.raw});
            len_next  = rice_pkg::len_t'(`RICE_QMAX + `RICE_RAW_W);
        end else begin
            // Ones, terminating zero, then K remainder bits
            code_next = (unary_ones << (`RICE_K + 1)) | rice_pkg::code_t'(i_split.rem);
            len_next  = rice_pkg::len_t'(i_split.quot) + rice_pkg::len_t'(`RICE_K + 1);
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_code.valid <= 1'b0;
            o_code.flush <= 1'b0;
        end else begin
            o_code.valid <= i_split.valid;
            // Flush rides behind any sample already in flight
            o_code.flush <= i_split.flush;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_split.valid) begin
            o_code.code <= code_next;
            o_code.len  <= len_next;
        end
    end

endmodule

// File: rtl/rice_coder_top.sv
// Rice coder top. K set by RICE_K at build time, i_flush never with i_valid, no back-pressure
`timescale 1ns/1ps

module rice_coder_top (
    input  logic             i_clk,
    input  logic             i_arst_n,
    input  logic             i_valid,
    input  rice_pkg::value_t i_value,
    input  logic             i_flush,
    output logic             o_word_valid,
    output rice_pkg::word_t  o_word
);

    split_if split_bus ();
    code_if  code_bus ();

    // Stage 1, quotient and remainder
    rice_split split_i (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_valid  (i_valid),
        .i_value  (i_value),
        .i_flush  (i_flush),
        .o_split  (split_bus.src)
    );

    // Stage 2, code word and length
    rice_code_build build_i (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_split  (split_bus.dst),
        .o_code   (code_bus.src)
    );

    // Stage 3, word packing
    bit_packer pack_i (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_code       (code_bus.dst),
        .o_word_valid (o_word_valid),
        .o_word       (o_word)
    );

endmodule

// File: rtl/rice_defs.svh
// Build-time constants. K must stay in 0..15 and every code must fit in 31 bits
`ifndef RICE_DEFS_SVH
`define RICE_DEFS_SVH

// Number of remainder bits, divisor is 2**RICE_K
`define RICE_K 2

// Quotients at or above this value are sent as an escape
`define RICE_QMAX 15

// Width of one raw input sample
`define RICE_RAW_W 16

`endif

// File: rtl/rice_if.sv
// Stage-to-stage buses of the Rice coder. No handshake, valid and flush are one-cycle strobes
`timescale 1ns/1ps

// Split stage to code build stage
interface split_if;
    logic               valid;
    rice_pkg::quot_t    quot;
    rice_pkg::rem_t     rem;
    logic               esc;
    rice_pkg::value_t   raw;
    logic               flush;

    modport src (
        output valid, quot, rem, esc, raw, flush
    );

    modport dst (
        input valid, quot, rem, esc, raw, flush
    );
endinterface

// Code build stage to bit packer
interface code_if;
    logic               valid;
    rice_pkg::code_t    code;
    rice_pkg::len_t     len;
    logic               flush;

    modport src (
        output valid, code, len, flush
    );

    modport dst (
        input valid, code, len, flush
    );
endinterface

// File: rtl/rice_pkg.sv
// Shared vector types for the Rice coder. Widths assume RICE_RAW_W of 16 and 32-bit words
`include "rice_defs.svh"

package rice_pkg;

    // One unsigned input sample
    typedef logic [`RICE_RAW_W-1:0] value_t;

    // Quotient after the escape clamp
    typedef logic [3:0] quot_t;

    // Remainder field, only the low RICE_K bits carry data
    typedef logic [`RICE_RAW_W-1:0] rem_t;

    // Right-aligned code word and its length in bits (1 to 31)
    typedef logic [31:0] code_t;
    typedef logic [5:0]  len_t;

    // Packed output word and the packer fill count
    typedef logic [31:0] word_t;
    typedef logic [5:0]  fill_t;

endpackage

// File: rtl/rice_split.sv
// Stage 1. Splits each sample by 2**RICE_K, flags escapes, and expects i_flush apart from i_valid
`timescale 1ns/1ps
`include "rice_defs.svh"

module rice_split (
    input  logic              i_clk,
    input  logic              i_arst_n,
    input  logic              i_valid,
    input  rice_pkg::value_t  i_value,
    input  logic              i_flush,
    split_if.src              o_split
);

    localparam rice_pkg::value_t REM_MASK = rice_pkg::value_t'((1 << `RICE_K) - 1);

    rice_pkg::value_t  quot_full;
    logic              esc_next;

    always_comb begin
        quot_full = i_value >> `RICE_K;
        // Anything this large would need a unary run of 15 or more
        esc_next  = (quot_full >= rice_pkg::value_t'(`RICE_QMAX));
    end

    // Strobes
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_split.valid <= 1'b0;
            o_split.flush <= 1'b0;
        end else begin
            o_split.valid <= i_valid;
            o_split.flush <= i_flush;
        end
    end

    // Sample fields load only with a new sample
    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_split.esc <= esc_next;
            o_split.raw <= i_value;
            o_split.rem <= i_value & REM_MASK;
            if (esc_next) begin
                o_split.quot <= rice_pkg::quot_t'(`RICE_QMAX);
            end else begin
                o_split.quot <= quot_full[3:0];
            end
        end
    end

endmodule
